//--- files.f
+incdir+src
src/scatter_data_pkg.sv
src/scatter_bus_pkg.sv
src/lane_if.sv
src/block_feeder.sv
src/priority_encoder.sv
src/scatter_threshold.sv
src/result_collector.sv
src/outlier_scatter_top.sv
sim/tb_outlier_scatter.sv

//--- run.sh
#!/bin/sh
# build and run the outlier scatter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f files.f \
    --top-module tb_outlier_scatter \
    --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build error"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

//--- sim/tb_outlier_scatter.sv
`timescale 1ns/1ps
`include "scatter_defs.svh"

module tb_outlier_scatter;

    localparam int CLK_NS = 4;
    localparam int DRIVE_NS = 1;
    // bus transactions of the reset, fixed, boundary, random and count tests
    localparam int N_TRANS = 2 + 13 + 15 + 320 + 195;
    // request, ack and idle cycle plus one spare
    localparam int CYC_PER_TRANS = 4;
    localparam int TIMEOUT_NS = (N_TRANS * CYC_PER_TRANS + 100) * CLK_NS;

    logic        clk;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_i;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_o;
    logic        wb_ack;

    int          check_n;
    int          err_n;
    int          test_check_n;
    int          test_err_n;
    int          blk_cnt;
    string       cur_test;
    logic [31:0] lfsr_q;

    outlier_scatter_top DUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_sel   (wb_sel),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // single cycle ack
    ack_single: assert property (@(posedge clk) disable iff (!arst_n) wb_ack |=> !wb_ack)
        else begin
            $display("handshake: wb_ack stayed high for two cycles in a row");
            err_n++;
        end

    // ack only answers a live request
    ack_on_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
        else begin
            $display("handshake: wb_ack rose without cyc and stb high");
            err_n++;
        end

    // fibonacci lfsr with taps 32 22 2 1
    // one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int b = 0; b < n; b++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // inputs change only DRIVE_NS after a rising edge
    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_NS);
    endtask

    // hold the request through the ack cycle
    // the idle cycle after it lets a DATA write reach the collector
    task automatic bus_cycle(input logic we, input logic [2:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_i = wdata;
        do begin
            next_cycle();
        end while (!wb_ack);
        // read data valid with ack
        rdata = wb_dat_o;
        // request drops in the cycle after ack
        next_cycle();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        next_cycle();
    endtask

    task automatic bus_write(input logic [2:0] adr, input logic [31:0] wdata);
        logic [31:0] unused_rd;
        bus_cycle(1'b1, adr, wdata, unused_rd);
    endtask

    task automatic bus_read(input logic [2:0] adr, output logic [31:0] rdata);
        bus_cycle(1'b0, adr, 32'h0, rdata);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        check_n++;
        test_check_n++;
        assert (act === exp)
            else begin
                $display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
                err_n++;
                test_err_n++;
            end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_check_n = 0;
        test_err_n = 0;
    endtask

    task automatic end_test();
        $display("test %s done: %0d checks, %0d errors", cur_test, test_check_n, test_err_n);
    endtask

    // expected split of one bus word
    // flag above +thr or below -thr
    // first HIGH_SLOTS flags per lane win
    task automatic model_block(input logic [31:0] data, input int thr,
                               output logic [31:0] high, output logic [31:0] low,
                               output logic [7:0] masks, output logic [1:0] ovf);
        int v;
        int hits;
        int k;
        high = '0;
        low = '0;
        masks = '0;
        ovf = '0;
        for (int l = 0; l < `LANES; l++) begin
            hits = 0;
            for (int i = 0; i < `BLOCK_ELEMS; i++) begin
                k = l * `BLOCK_ELEMS + i;
                v = $signed(data[`ELEM_W*k +: `ELEM_W]);
                if ((v > thr || v < -thr) && hits < `HIGH_SLOTS) begin
                    high[`ELEM_W*k +: `ELEM_W] = data[`ELEM_W*k +: `ELEM_W];
                    masks[k] = 1'b1;
                end else begin
                    low[`ELEM_W*k +: `ELEM_W] = data[`ELEM_W*k +: `ELEM_W];
                end
                if (v > thr || v < -thr) begin
                    hits++;
                end
            end
            ovf[l] = (hits > `HIGH_SLOTS);
        end
    endtask

    // write one word and read back all three result registers
    task automatic scatter_and_check(input logic [31:0] data, input int thr);
        logic [31:0] exp_high;
        logic [31:0] exp_low;
        logic [7:0]  exp_masks;
        logic [1:0]  exp_ovf;
        logic [31:0] exp_status;
        logic [31:0] high;
        logic [31:0] low;
        logic [31:0] status;
        model_block(data, thr, exp_high, exp_low, exp_masks, exp_ovf);
        bus_write(`ADDR_DATA, data);
        blk_cnt++;
        bus_read(`ADDR_HIGH, high);
        bus_read(`ADDR_LOW, low);
        bus_read(`ADDR_STATUS, status);
        // masks in the low byte with ovf and count above them
        exp_status = {14'h0, blk_cnt[7:0], exp_ovf, exp_masks};
        check_value("high", exp_high, high);
        check_value("low", exp_low, low);
        check_value("status", exp_status, status);
        // copies never overlap and together rebuild the word
        check_value("high and low overlap", 32'h0, high & low);
        check_value("high or low", data, high | low);
    endtask

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: simulation did not finish within %0d ns", TIMEOUT_NS);
        $display("test failed");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] rd2;
        int          thr;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_i = '0;
        wb_sel = 4'hf;
        arst_n = 1'b0;
        check_n = 0;
        err_n = 0;
        blk_cnt = 0;
        lfsr_q = 32'hd86915f3;
        repeat (5) @(posedge clk);
        #(DRIVE_NS);
        arst_n = 1'b1;
        next_cycle();

        // reset values
        start_test("reset");
        bus_read(`ADDR_CFG, rd);
        check_value("config", 32'd7, rd);
        bus_read(`ADDR_STATUS, rd);
        check_value("status", 32'h0, rd);
        end_test();

        // one, two and four outliers per lane at threshold 3
        start_test("fixed");
        bus_write(`ADDR_CFG, 32'd3);
        scatter_and_check(32'h2A00_0E51, 3);
        scatter_and_check(32'h00C4_160B, 3);
        scatter_and_check(32'h6A5C_9487, 3);
        end_test();

        // +-thr stay low while +-(thr+1) and -8 go high
        start_test("boundary");
        bus_write(`ADDR_CFG, 32'd3);
        scatter_and_check(32'h3008_C4D3, 3);
        // only -8 passes threshold 7
        bus_write(`ADDR_CFG, 32'd7);
        scatter_and_check(32'h5888_0897, 7);
        // threshold 0 flags any nonzero element
        bus_write(`ADDR_CFG, 32'd0);
        scatter_and_check(32'h0F01_2030, 0);
        end_test();

        start_test("random");
        for (int n = 0; n < 64; n++) begin
            thr = int'(rand_bits(3));
            bus_write(`ADDR_CFG, 32'(thr));
            scatter_and_check(rand_bits(32), thr);
        end
        end_test();

        // count follows DATA writes only
        // wraps at 256
        start_test("count");
        bus_read(`ADDR_STATUS, rd);
        check_value("count", 32'(blk_cnt % 256), (rd >> 10) & 32'hff);
        bus_write(`ADDR_CFG, 32'd5);
        bus_read(`ADDR_CFG, rd2);
        check_value("config", 32'd5, rd2);
        bus_read(`ADDR_STATUS, rd2);
        check_value("count after config", 32'(blk_cnt % 256), (rd2 >> 10) & 32'hff);
        while (blk_cnt < 260) begin
            bus_write(`ADDR_DATA, rand_bits(32));
            blk_cnt++;
        end
        bus_read(`ADDR_STATUS, rd);
        check_value("count wrapped", 32'(blk_cnt % 256), (rd >> 10) & 32'hff);
        end_test();

        $display("checks: %0d, errors: %0d", check_n, err_n);
        if (err_n == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- src/block_feeder.sv
`timescale 1ns/1ps
`include "scatter_defs.svh"

module block_feeder (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  logic [2:0]                         wb_adr,
    input  logic [scatter_bus_pkg::WORD_W-1:0] wb_dat_i,
    output logic [scatter_bus_pkg::WORD_W-1:0] wb_dat_o,
    output logic                               wb_ack,
    output scatter_bus_pkg::reg_addr_e         rd_adr,
    output logic                               rd_en,
    input  logic [scatter_bus_pkg::WORD_W-1:0] rd_data,
    lane_if.feeder                             lanes [0:`LANES-1]
);

    logic                                  bus_req;
    logic                                  wr_req;
    logic                                  rd_req;
    scatter_bus_pkg::reg_addr_e            adr;
    scatter_bus_pkg::bus_word_u            wr_word;
    scatter_bus_pkg::bus_word_u            rd_word;
    logic [`ELEM_W-2:0]                    thr_q;
    logic                                  blk_vld_q;
    scatter_data_pkg::block_t [`LANES-1:0] blk_q;

    // new request only while no ack is out
    // master still holds stb in the ack cycle
    assign bus_req = wb_cyc & wb_stb & ~wb_ack;
    assign wr_req = bus_req & wb_we;
    assign rd_req = bus_req & ~wb_we;

    // addresses 5..7 fall outside the enum, caught by the default arms
    assign adr = scatter_bus_pkg::reg_addr_e'(wb_adr);
    assign wr_word = wb_dat_i;

    // collector side of the read path, address held by the master
    assign rd_adr = adr;
    assign rd_en = rd_req;

    // read mux
    // CONFIG is local, result registers come from the collector
    // DATA is write only
    always_comb begin
        rd_word = '0;
        case (adr)
            scatter_bus_pkg::REG_CFG:    rd_word.cfg.thr = thr_q;
            scatter_bus_pkg::REG_HIGH:   rd_word = rd_data;
            scatter_bus_pkg::REG_LOW:    rd_word = rd_data;
            scatter_bus_pkg::REG_STATUS: rd_word = rd_data;
            default:                     rd_word = '0;
        endcase
    end

    // ack, lane valid and threshold
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
            blk_vld_q <= 1'b0;
            // widest threshold, only -8 is flagged
            thr_q <= '1;
        end else begin
            wb_ack <= bus_req;
            blk_vld_q <= wr_req && (adr == scatter_bus_pkg::REG_DATA);
            if (wr_req && (adr == scatter_bus_pkg::REG_CFG)) begin
                thr_q <= wr_word.cfg.thr;
            end
        end
    end

    // block and read data, loaded with their strobes
    always_ff @(posedge clk) begin
        if (wr_req && (adr == scatter_bus_pkg::REG_DATA)) begin
            blk_q <= wr_word.blocks;
        end
        if (rd_req) begin
            wb_dat_o <= rd_word;
        end
    end

    // each lane takes its slice of the word
    for (genvar l = 0; l < `LANES; l++) begin : g_lane
        assign lanes[l].blk = blk_q[l];
        assign lanes[l].thr = thr_q;
        assign lanes[l].vld = blk_vld_q;
    end

endmodule

//--- src/lane_if.sv
`timescale 1ns/1ps
`include "scatter_defs.svh"

interface lane_if;

    // feeder to lane
    scatter_data_pkg::block_t   blk;
    logic [`ELEM_W-2:0]         thr;
    // one cycle pulse, lane samples blk and thr on this edge
    logic                       vld;

    // lane to collector
    scatter_data_pkg::block_t   high_blk;
    scatter_data_pkg::block_t   low_blk;
    scatter_data_pkg::lane_mask_t mask;
    // more flagged elements than slots
    logic                       ovf;
    // one cycle after vld
    logic                       res_vld;

    modport feeder (
        output blk,
        output thr,
        output vld
    );

    modport lane (
        input  blk,
        input  thr,
        input  vld,
        output high_blk,
        output low_blk,
        output mask,
        output ovf,
        output res_vld
    );

    modport collector (
        input  high_blk,
        input  low_blk,
        input  mask,
        input  ovf,
        input  res_vld
    );

endinterface

//--- src/outlier_scatter_top.sv
`timescale 1ns/1ps
`include "scatter_defs.svh"

module outlier_scatter_top (
    input  logic                               clk,
    input  logic                               arst_n,
    // Wishbone classic slave
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  logic [2:0]                         wb_adr,
    input  logic [scatter_bus_pkg::WORD_W-1:0] wb_dat_i,
    // byte enables, every register is full word
    input  logic [3:0]                         wb_sel,
    output logic [scatter_bus_pkg::WORD_W-1:0] wb_dat_o,
    output logic                               wb_ack
);

    // read path between feeder and collector
    scatter_bus_pkg::reg_addr_e         rd_adr;
    logic                               rd_en;
    logic [scatter_bus_pkg::WORD_W-1:0] rd_data;

    // one link per lane
    lane_if lanes [0:`LANES-1] ();

    // bus front end, threshold register, block issue
    block_feeder u_feeder (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .rd_adr   (rd_adr),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .lanes    (lanes)
    );

    // scatter lanes, one block each
    for (genvar l = 0; l < `LANES; l++) begin : g_lane
        scatter_threshold u_lane (
            .clk    (clk),
            .arst_n (arst_n),
            .lane   (lanes[l])
        );
    end

    // result registers and block count
    result_collector u_collector (
        .clk     (clk),
        .arst_n  (arst_n),
        .rd_adr  (rd_adr),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .lanes   (lanes)
    );

endmodule

//--- src/priority_encoder.sv
`timescale 1ns/1ps
`include "scatter_defs.svh"

module priority_encoder (
    input  scatter_data_pkg::lane_mask_t req,
    output scatter_data_pkg::lane_mask_t mask,
    output logic                         ovf
);

    // enough bits to count every element of a block
    localparam int CNT_W = $clog2(`BLOCK_ELEMS + 1);

    logic [CNT_W-1:0] set_cnt;

    // walk from index 0 up
    // first HIGH_SLOTS set bits survive, later ones are dropped
    always_comb begin
        set_cnt = '0;
        mask = '0;
        for (int i = 0; i < `BLOCK_ELEMS; i++) begin
            if (req[i]) begin
                // slot still free
                if (set_cnt < CNT_W'(`HIGH_SLOTS)) begin
                    mask[i] = 1'b1;
                end
                set_cnt = set_cnt + 1'b1;
            end
        end
    end

    // more requests than slots
    assign ovf = (set_cnt > CNT_W'(`HIGH_SLOTS));

endmodule

//--- src/result_collector.sv
`timescale 1ns/1ps
`include "scatter_defs.svh"

module result_collector (
    input  logic                               clk,
    input  logic                               arst_n,
    input  scatter_bus_pkg::reg_addr_e         rd_adr,
    input  logic                               rd_en,
    output logic [scatter_bus_pkg::WORD_W-1:0] rd_data,
    lane_if.collector                          lanes [0:`LANES-1]
);

    // lane outputs gathered into vectors
    scatter_data_pkg::block_t [`LANES-1:0]     high_in;
    scatter_data_pkg::block_t [`LANES-1:0]     low_in;
    scatter_data_pkg::lane_mask_t [`LANES-1:0] mask_in;
    logic [`LANES-1:0]                         ovf_in;
    logic                                      blk_done;

    // latest results
    scatter_data_pkg::block_t [`LANES-1:0]     high_q;
    scatter_data_pkg::block_t [`LANES-1:0]     low_q;
    scatter_data_pkg::lane_mask_t [`LANES-1:0] mask_q;
    logic [`LANES-1:0]                         ovf_q;
    logic [scatter_bus_pkg::CNT_W-1:0]         count_q;

    scatter_bus_pkg::bus_word_u                rd_word;

    for (genvar l = 0; l < `LANES; l++) begin : g_lane
        assign high_in[l] = lanes[l].high_blk;
        assign low_in[l] = lanes[l].low_blk;
        assign mask_in[l] = lanes[l].mask;
        assign ovf_in[l] = lanes[l].ovf;
    end

    // lanes run in lockstep, lane 0 marks the block
    assign blk_done = lanes[0].res_vld;

    // newer results overwrite older ones
    // count wraps at 256
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            high_q <= '0;
            low_q <= '0;
            mask_q <= '0;
            ovf_q <= '0;
            count_q <= '0;
        end else if (blk_done) begin
            high_q <= high_in;
            low_q <= low_in;
            mask_q <= mask_in;
            ovf_q <= ovf_in;
            count_q <= count_q + 1'b1;
        end
    end

    // read words
    // HIGH and LOW as elements, STATUS as fields
    always_comb begin
        rd_word = '0;
        case (rd_adr)
            scatter_bus_pkg::REG_HIGH: rd_word.blocks = high_q;
            scatter_bus_pkg::REG_LOW:  rd_word.blocks = low_q;
            scatter_bus_pkg::REG_STATUS: begin
                rd_word.status.masks = mask_q;
                rd_word.status.ovf = ovf_q;
                rd_word.status.count = count_q;
            end
            default: rd_word = '0;
        endcase
    end

    // quiet bus when no read is asked for
    assign rd_data = rd_en ? rd_word : '0;

endmodule

//--- src/scatter_bus_pkg.sv
`include "scatter_defs.svh"

package scatter_bus_pkg;

    // one bus word holds a block from every lane
    localparam int WORD_W = `LANES * scatter_data_pkg::BLOCK_W;

    // block counter width in STATUS
    localparam int CNT_W = 8;

    // padding of the register views
    localparam int CFG_PAD_W = WORD_W - (`ELEM_W - 1);
    localparam int STATUS_PAD_W = WORD_W - CNT_W - `LANES - `LANES * scatter_data_pkg::MASK_W;

    // register map
    typedef enum logic [2:0] {
        REG_CFG    = `ADDR_CFG,
        REG_DATA   = `ADDR_DATA,
        REG_HIGH   = `ADDR_HIGH,
        REG_LOW    = `ADDR_LOW,
        REG_STATUS = `ADDR_STATUS
    } reg_addr_e;

    // CONFIG, threshold magnitude in the low bits
    typedef struct packed {
        logic [CFG_PAD_W-1:0] rsvd;
        logic [`ELEM_W-2:0]   thr;
    } cfg_t;

    // STATUS: masks in [7:0], overflow in [9:8], count in [17:10]
    typedef struct packed {
        logic [STATUS_PAD_W-1:0]                          rsvd;
        logic [CNT_W-1:0]                                 count;
        logic [`LANES-1:0]                                ovf;
        scatter_data_pkg::lane_mask_t [`LANES-1:0]        masks;
    } status_t;

    // one bus word, read as elements or as register fields
    typedef union packed {
        scatter_data_pkg::block_t [`LANES-1:0] blocks;
        cfg_t                                  cfg;
        status_t                               status;
    } bus_word_u;

endpackage

//--- src/scatter_data_pkg.sv
`include "scatter_defs.svh"

package scatter_data_pkg;

    // one signed tensor element
    typedef logic signed [`ELEM_W-1:0] elem_t;

    // one lane block, element 0 in the low bits
    // element selects keep the signed elem_t type
    typedef elem_t [`BLOCK_ELEMS-1:0] block_t;

    // one bit per element of a block
    // set = element goes to the high precision copy
    typedef logic [`BLOCK_ELEMS-1:0] lane_mask_t;

    // width checks on the data path types
    localparam int BLOCK_W = `BLOCK_ELEMS * `ELEM_W;
    localparam int MASK_W = `BLOCK_ELEMS;

endpackage

//--- src/scatter_defs.svh
`ifndef SCATTER_DEFS_SVH
`define SCATTER_DEFS_SVH

// tensor element width, signed
`define ELEM_W 4

// elements per lane block
`define BLOCK_ELEMS 4

// scatter lanes; one bus word carries one block per lane
`define LANES 2

// max elements per block routed to high precision
`define HIGH_SLOTS 2

// register map, word addresses
`define ADDR_CFG 3'd0
`define ADDR_DATA 3'd1
`define ADDR_HIGH 3'd2
`define ADDR_LOW 3'd3
`define ADDR_STATUS 3'd4

`endif

//--- src/scatter_threshold.sv
`timescale 1ns/1ps
`include "scatter_defs.svh"

module scatter_threshold (
    input  logic  clk,
    input  logic  arst_n,
    lane_if.lane  lane
);

    logic signed [`ELEM_W-1:0]    pos_lim;
    logic signed [`ELEM_W-1:0]    neg_lim;
    scatter_data_pkg::lane_mask_t outlier;
    scatter_data_pkg::lane_mask_t sel;
    logic                         sel_ovf;
    scatter_data_pkg::block_t     high_c;
    scatter_data_pkg::block_t     low_c;

    // threshold is a magnitude, zero extend then negate
    // thr 7 gives -7, still inside the element range
    assign pos_lim = $signed({1'b0, lane.thr});
    assign neg_lim = -pos_lim;

    // outlier flags
    // values equal to +thr or -thr stay low precision
    for (genvar i = 0; i < `BLOCK_ELEMS; i++) begin : g_flag
        assign outlier[i] = ($signed(lane.blk[i]) > pos_lim) ||
                            ($signed(lane.blk[i]) < neg_lim);
    end

    // keep the lowest indexed outliers up to the slot count
    priority_encoder u_enc (
        .req  (outlier),
        .mask (sel),
        .ovf  (sel_ovf)
    );

    // split into two copies
    // every element lands in exactly one of them
    for (genvar i = 0; i < `BLOCK_ELEMS; i++) begin : g_split
        assign high_c[i] = sel[i] ? lane.blk[i] : '0;
        assign low_c[i] = sel[i] ? '0 : lane.blk[i];
    end

    // result valid, one cycle behind vld
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane.res_vld <= 1'b0;
        end else begin
            lane.res_vld <= lane.vld;
        end
    end

    // results, only loaded with a new block
    always_ff @(posedge clk) begin
        if (lane.vld) begin
            lane.high_blk <= high_c;
            lane.low_blk <= low_c;
            lane.mask <= sel;
            lane.ovf <= sel_ovf;
        end
    end

endmodule
